/* vlog.f */
+incdir+.
decode_pkg.sv
imm_gen.sv
op_decoder.sv
decode_perf.sv
warp_decode.sv
tb_warp_decode.sv

/* Bender.yml */
package:
  name: warp_decode

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - decode_pkg.sv
      - imm_gen.sv
      - op_decoder.sv
      - decode_perf.sv
      - warp_decode.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_warp_decode.sv

/* decode_ref.svh */
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Expected decode of one instruction, straight from the ISA field layout
function automatic void ref_decode(
    input  logic [31:0]          instr,
    output decode_pkg::decoded_t d,
    output logic                 stall,
    output logic                 jn
);
    logic [2:0]  f3;
    logic        has_rd;
    logic [31:0] imm_i;
    f3     = instr[14:12];
    imm_i  = {{20{instr[31]}}, instr[31:20]};
    d      = '0;
    stall  = 1'b0;
    jn     = 1'b0;
    has_rd = 1'b0;
    case (instr[6:0])
        `INST_R, `INST_I: begin
            case (f3)
                3'h0: d.op_type = (instr[6:0] == `INST_R && instr[30]) ? 4'd1 : 4'd0;
                3'h1: d.op_type = 4'd2;
                3'h2: d.op_type = 4'd3;
                3'h3: d.op_type = 4'd4;
                3'h4: d.op_type = 4'd5;
                3'h5: d.op_type = instr[30] ? 4'd7 : 4'd6;
                3'h6: d.op_type = 4'd8;
                3'h7: d.op_type = 4'd9;
            endcase
            has_rd = 1'b1;
            d.rs1  = instr[19:15];
            if (instr[6:0] == `INST_R) begin
                d.rs2 = instr[24:20];
            end else begin
                d.use_imm = 1'b1;
                d.imm = (f3 == 3'h1 || f3 == 3'h5) ? {27'b0, instr[24:20]} : imm_i;
            end
        end
        `INST_LUI, `INST_AUIPC: begin
            d.op_type = (instr[6:0] == `INST_LUI) ? 4'd10 : 4'd11;
            d.use_pc  = (instr[6:0] == `INST_AUIPC);
            d.use_imm = 1'b1;
            d.imm     = {instr[31:12], 12'b0};
            has_rd    = 1'b1;
        end
        `INST_JAL: begin
            d.op_type = 4'd8;
            d.op_mod  = 3'd1;
            d.use_pc  = 1'b1;
            d.use_imm = 1'b1;
            d.imm     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            has_rd    = 1'b1;
            stall     = 1'b1;
        end
        `INST_JALR: begin
            d.op_type = 4'd9;
            d.op_mod  = 3'd1;
            d.use_imm = 1'b1;
            d.imm     = imm_i;
            d.rs1     = instr[19:15];
            has_rd    = 1'b1;
            stall     = 1'b1;
        end
        `INST_B: begin
            // Codes 2 and 3 are not branches and fall back to EQ
            d.op_type = (f3[2:1] == 2'b01) ? 4'd0 : {1'b0, f3};
            d.op_mod  = 3'd1;
            d.use_pc  = 1'b1;
            d.use_imm = 1'b1;
            d.imm     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            d.rs1     = instr[19:15];
            d.rs2     = instr[24:20];
            stall     = 1'b1;
        end
        `INST_FENCE: begin
            d.ex_type = decode_pkg::EX_LSU;
            d.op_mod  = 3'd1;
        end
        `INST_SYS: begin
            has_rd = 1'b1;
            if (f3[1:0] != 2'b00) begin
                d.ex_type = decode_pkg::EX_CSR;
                d.op_type = {2'b00, f3[1:0]};
                d.use_imm = f3[2];
                d.imm     = {15'b0, instr[19:15], instr[31:20]};
                d.rs1     = f3[2] ? 5'd0 : instr[19:15];
            end else begin
                case (instr[31:20])
                    12'h001: d.op_type = 4'd11;
                    12'h002: d.op_type = 4'd12;
                    12'h102: d.op_type = 4'd13;
                    12'h302: d.op_type = 4'd14;
                    default: d.op_type = 4'd10;
                endcase
                d.op_mod  = 3'd1;
                d.use_pc  = 1'b1;
                d.use_imm = 1'b1;
                d.imm     = 32'd4;
                stall     = 1'b1;
            end
        end
        `INST_L: begin
            d.ex_type = decode_pkg::EX_LSU;
            d.op_type = {1'b0, f3};
            d.imm     = imm_i;
            d.rs1     = instr[19:15];
            has_rd    = 1'b1;
        end
        `INST_S: begin
            d.ex_type = decode_pkg::EX_LSU;
            d.op_type = {1'b1, f3};
            d.imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            d.rs1     = instr[19:15];
            d.rs2     = instr[24:20];
        end
        `INST_GPGPU: begin
            d.ex_type = decode_pkg::EX_GPU;
            if (f3 <= 3'h5 && f3 != 3'h3)
                d.rs1 = instr[19:15];
            if (f3 == 3'h1 || f3 == 3'h4)
                d.rs2 = instr[24:20];
            case (f3)
                3'h0: d.op_type = instr[20] ? 4'd5 : 4'd0; // PRED or TMC
                3'h1: d.op_type = 4'd1;
                3'h2: d.op_type = 4'd2;
                3'h3: d.op_type = 4'd3;
                3'h4: d.op_type = 4'd4;
                3'h5: begin
                    d.ex_type = decode_pkg::EX_LSU;
                    d.op_type = 4'd2;
                    d.op_mod  = 3'd2;
                end
                default: ;
            endcase
            stall = (f3 == 3'h0 || f3 == 3'h2 || f3 == 3'h4);
            jn    = (f3 == 3'h3);
        end
        default: ;
    endcase
    if (has_rd)
        d.rd = instr[11:7];
    d.wb = has_rd && (instr[11:7] != 5'd0);
endfunction

// Counter rule, adds the active thread count to the matching counter
function automatic decode_pkg::perf_cnt_t ref_count(
    input decode_pkg::perf_cnt_t     p,
    input decode_pkg::decoded_t      d,
    input logic [`NUM_THREADS-1:0]   tmask
);
    decode_pkg::perf_cnt_t n;
    int                    active;
    n      = p;
    active = 0;
    for (int i = 0; i < `NUM_THREADS; i++)
        active += tmask[i];
    if (d.ex_type == decode_pkg::EX_LSU && d.op_mod == 3'd0) begin
        if (d.op_type[3])
            n.stores = n.stores + active;
        else
            n.loads = n.loads + active;
    end
    if (d.ex_type == decode_pkg::EX_ALU && d.op_mod == 3'd1)
        n.branches = n.branches + active;
    return n;
endfunction

`endif

/* tb_warp_decode.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module tb_warp_decode;

    localparam int N_ALU      = 40;
    localparam int N_MEM      = 60;
    localparam int N_SYS      = 30;
    localparam int N_GPU      = 30;
    localparam int N_MIX      = 300;
    localparam int HOLD       = 4;
    localparam int MAX_CYCLES = 5 + N_ALU + N_MEM + N_SYS + N_GPU + 2 * (HOLD + 1)
                              + 6 * N_MIX + 20;

    logic                    clk;
    logic                    reset;
    logic                    fetch_valid;
    decode_pkg::fetch_rsp_t  fetch_rsp;
    logic                    fetch_ready;
    logic                    decode_valid;
    decode_pkg::decode_rsp_t decode_rsp;
    logic                    decode_ready;
    logic                    wstall_valid;
    decode_pkg::wstall_t     wstall;
    logic                    join_valid;
    decode_pkg::join_t       join_out;
    decode_pkg::perf_cnt_t   perf;

    decode_pkg::decoded_t    exp_dec;
    decode_pkg::decode_rsp_t exp_rsp;
    decode_pkg::perf_cnt_t   exp_perf;
    logic                    exp_stall;
    logic                    exp_join;
    logic                    xfer;
    int                      n_checks = 0;
    int                      n_errors = 0;
    int                      cycle_count = 0;

    `include "decode_ref.svh"

    warp_decode dut (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_rsp    (fetch_rsp),
        .fetch_ready  (fetch_ready),
        .decode_valid (decode_valid),
        .decode_rsp   (decode_rsp),
        .decode_ready (decode_ready),
        .wstall_valid (wstall_valid),
        .wstall       (wstall),
        .join_valid   (join_valid),
        .join_out     (join_out),
        .perf         (perf)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Picks x0 about a quarter of the time
    function automatic logic [4:0] rand_reg();
        rand_reg = ($urandom_range(3) == 0) ? 5'd0 : 5'($urandom);
    endfunction

    function automatic logic [31:0] gen_instr(input int kind);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] ret_code;
        r   = $urandom;
        f3  = 3'($urandom);
        rd  = rand_reg();
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        case (kind)
            0: gen_instr = {1'b0, r[30], 5'b0, rs2, rs1, f3, rd, `INST_R};
            1: begin
                if (f3 == 3'h1)
                    r[31:25] = 7'h00;
                else if (f3 == 3'h5)
                    r[31:25] = {1'b0, r[30], 5'b0}; // SRLI or SRAI
                gen_instr = {r[31:20], rs1, f3, rd, `INST_I};
            end
            2: gen_instr = {r[31:12], rd, (r[0] ? `INST_LUI : `INST_AUIPC)};
            3: begin
                if (r[0])
                    gen_instr = {r[31:12], rd, `INST_JAL};
                else
                    gen_instr = {r[31:20], rs1, 3'b0, rd, `INST_JALR};
            end
            4: begin
                if (f3[2:1] == 2'b01)
                    f3[1] = 1'b0;
                gen_instr = {r[31:25], rs2, rs1, f3, r[11:7], `INST_B};
            end
            5: begin
                if (f3 == 3'h3 || f3 >= 3'h6)
                    f3 = 3'h2;
                gen_instr = {r[31:20], rs1, f3, rd, `INST_L};
            end
            6: begin
                f3 = {1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0]};
                gen_instr = {r[31:25], rs2, rs1, f3, r[11:7], `INST_S};
            end
            7: gen_instr = {4'b0, r[27:20], 13'b0, `INST_FENCE};
            8: begin
                if (f3[1:0] == 2'b00)
                    f3[0] = 1'b1;
                gen_instr = {r[31:20], rs1, f3, rd, `INST_SYS};
            end
            9: begin
                case ($urandom_range(4))
                    0: ret_code = 12'h000;
                    1: ret_code = 12'h001;
                    2: ret_code = 12'h002;
                    3: ret_code = 12'h102;
                    default: ret_code = 12'h302;
                endcase
                gen_instr = {ret_code, 5'b0, 3'b0, rd, `INST_SYS};
            end
            default: begin
                if (f3 > 3'h5)
                    f3 = f3 - 3'h3;
                gen_instr = {7'b0, rs2, rs1, f3, rd, `INST_GPGPU};
            end
        endcase
    endfunction

    task automatic drive_fetch(input logic [31:0] instr);
        fetch_valid     <= 1'b1;
        fetch_rsp.uuid  <= `UUID_BITS'($urandom);
        fetch_rsp.wid   <= `NW_BITS'($urandom);
        fetch_rsp.tmask <= `NUM_THREADS'($urandom);
        fetch_rsp.pc    <= 32'($urandom) & ~32'h3;
        fetch_rsp.instr <= instr;
    endtask

    // Present one instruction and wait until the stage accepts it
    task automatic issue(input logic [31:0] instr, input bit random_ready);
        drive_fetch(instr);
        decode_ready <= random_ready ? ($urandom_range(3) != 0) : 1'b1;
        @(posedge clk);
        while (!fetch_ready) begin
            decode_ready <= ($urandom_range(3) != 0);
            @(posedge clk);
        end
    endtask

    task automatic hold_back(input logic [31:0] instr, input int cycles);
        drive_fetch(instr);
        decode_ready <= 1'b0;
        repeat (cycles) @(posedge clk);
        decode_ready <= 1'b1;
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'h10032310));
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch_rsp    = '0;
        decode_ready = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        repeat (N_ALU) issue(gen_instr($urandom_range(1)), 1'b0);
        repeat (N_MEM) issue(gen_instr($urandom_range(7, 2)), 1'b0);
        repeat (N_SYS) issue(gen_instr($urandom_range(9, 8)), 1'b0);
        repeat (N_GPU) issue(gen_instr(10), 1'b0);
        hold_back({7'b0, 5'd0, 5'd0, 3'h3, 5'd0, `INST_GPGPU}, HOLD); // JOIN
        hold_back({7'b0, 5'd3, 5'd2, 3'h4, 5'd0, `INST_GPGPU}, HOLD); // BAR
        repeat (N_MIX) issue(gen_instr($urandom_range(10)), 1'b1);

        fetch_valid  <= 1'b0;
        decode_ready <= 1'b1;
        repeat (3) @(posedge clk);

        $display("Run complete: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // Outputs settle after the rising edge, so compare on the falling edge
    always @(negedge clk) begin
        if (reset !== 1'b0) begin
            exp_perf = '0;
        end else begin
            xfer = fetch_valid && decode_ready;
            ref_decode(fetch_rsp.instr, exp_dec, exp_stall, exp_join);
            check_value(fetch_ready, decode_ready, "fetch_ready");
            check_value(decode_valid, fetch_valid, "decode_valid");
            if (fetch_valid) begin
                exp_rsp.uuid  = fetch_rsp.uuid;
                exp_rsp.wid   = fetch_rsp.wid;
                exp_rsp.tmask = fetch_rsp.tmask;
                exp_rsp.pc    = fetch_rsp.pc;
                exp_rsp.dec   = exp_dec;
                check_value(decode_rsp, exp_rsp,
                            $sformatf("decode_rsp instr %h", fetch_rsp.instr));
            end
            check_value(wstall_valid, xfer, "wstall_valid");
            if (xfer)
                check_value(wstall, {fetch_rsp.wid, exp_stall}, "wstall");
            check_value(join_valid, xfer && exp_join, "join_valid");
            if (xfer && exp_join)
                check_value(join_out, fetch_rsp.wid, "join_out");
            check_value(perf, exp_perf, "perf");
            if (xfer)
                exp_perf = ref_count(exp_perf, exp_dec, fetch_rsp.tmask);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

/* warp_decode.sv */
`timescale 1ns/1ps

module warp_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_valid,
    input  decode_pkg::fetch_rsp_t  fetch_rsp,
    output logic                    fetch_ready,
    output logic                    decode_valid,
    output decode_pkg::decode_rsp_t decode_rsp,
    input  logic                    decode_ready,
    output logic                    wstall_valid,
    output decode_pkg::wstall_t     wstall,
    output logic                    join_valid,
    output decode_pkg::join_t       join_out,
    output decode_pkg::perf_cnt_t   perf
);

    decode_pkg::decoded_t dec_core;
    decode_pkg::decoded_t decoded;
    decode_pkg::imm_fmt_e imm_fmt;
    logic [31:0]          imm;
    logic                 is_wstall;
    logic                 is_join;
    logic                 fire;

    op_decoder u_op_decoder (
        .instr     (fetch_rsp.instr),
        .dec       (dec_core),
        .imm_fmt   (imm_fmt),
        .is_wstall (is_wstall),
        .is_join   (is_join)
    );

    imm_gen u_imm_gen (
        .instr   (fetch_rsp.instr),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    always_comb begin
        decoded     = dec_core;
        decoded.imm = imm;
    end

    // Pass-through handshake, nothing is buffered here
    assign fetch_ready  = decode_ready;
    assign decode_valid = fetch_valid;
    assign fire         = fetch_valid && decode_ready;

    assign decode_rsp.uuid  = fetch_rsp.uuid;
    assign decode_rsp.wid   = fetch_rsp.wid;
    assign decode_rsp.tmask = fetch_rsp.tmask;
    assign decode_rsp.pc    = fetch_rsp.pc;
    assign decode_rsp.dec   = decoded;

    assign wstall_valid   = fire; // Every accepted instruction
    assign wstall.wid     = fetch_rsp.wid;
    assign wstall.stalled = is_wstall;

    assign join_valid   = fire && is_join;
    assign join_out.wid = fetch_rsp.wid;

    decode_perf u_decode_perf (
        .clk   (clk),
        .reset (reset),
        .fire  (fire),
        .tmask (fetch_rsp.tmask),
        .dec   (decoded),
        .perf  (perf)
    );

endmodule

/* decode_perf.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_perf (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fire,
    input  logic [`NUM_THREADS-1:0] tmask,
    input  decode_pkg::decoded_t    dec,
    output decode_pkg::perf_cnt_t   perf
);

    localparam int CNT_W = $clog2(`NUM_THREADS + 1);

    logic [CNT_W-1:0] active;
    logic             is_mem;
    logic             is_load;
    logic             is_store;
    logic             is_branch;

    function automatic logic [CNT_W-1:0] popcount(input logic [`NUM_THREADS-1:0] mask);
        logic [CNT_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < `NUM_THREADS; i++)
            sum = sum + CNT_W'(mask[i]);
        return sum;
    endfunction

    assign active    = popcount(tmask);
    assign is_mem    = (dec.ex_type == decode_pkg::EX_LSU) && (dec.op_mod == `MOD_BITS'(0));
    assign is_load   = is_mem && !dec.op_type[3];
    assign is_store  = is_mem && dec.op_type[3];
    assign is_branch = (dec.ex_type == decode_pkg::EX_ALU) && (dec.op_mod == `MOD_BITS'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            perf <= '0;
        end else if (fire) begin
            if (is_load)
                perf.loads <= perf.loads + `PERF_CTR_BITS'(active);
            if (is_store)
                perf.stores <= perf.stores + `PERF_CTR_BITS'(active);
            if (is_branch)
                perf.branches <= perf.branches + `PERF_CTR_BITS'(active);
        end
    end

endmodule

/* op_decoder.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module op_decoder (
    input  logic [31:0]          instr,
    output decode_pkg::decoded_t dec,
    output decode_pkg::imm_fmt_e imm_fmt,
    output logic                 is_wstall,
    output logic                 is_join
);

    logic [6:0]  opcode;
    logic [2:0]  func3;
    logic [6:0]  func7;
    logic [11:0] u_12;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        use_rd;

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign u_12   = instr[31:20];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        dec       = '0;
        imm_fmt   = decode_pkg::IMM_NONE;
        use_rd    = 1'b0;
        is_wstall = 1'b0;
        is_join   = 1'b0;
        dec.ex_type = decode_pkg::EX_ALU;

        case (opcode)
            `INST_I, `INST_R: begin
                case (func3)
                    3'h0: begin
                        // SUB only exists in the register form
                        if (opcode == `INST_R && func7[5])
                            dec.op_type = `INST_ALU_SUB;
                        else
                            dec.op_type = `INST_ALU_ADD;
                    end
                    3'h1: dec.op_type = `INST_ALU_SLL;
                    3'h2: dec.op_type = `INST_ALU_SLT;
                    3'h3: dec.op_type = `INST_ALU_SLTU;
                    3'h4: dec.op_type = `INST_ALU_XOR;
                    3'h5: dec.op_type = func7[5] ? `INST_ALU_SRA : `INST_ALU_SRL;
                    3'h6: dec.op_type = `INST_ALU_OR;
                    default: dec.op_type = `INST_ALU_AND;
                endcase
                use_rd  = 1'b1;
                dec.rd  = rd;
                dec.rs1 = rs1;
                if (opcode == `INST_I) begin
                    dec.use_imm = 1'b1;
                    imm_fmt = (func3[1:0] == 2'b01) ? decode_pkg::IMM_SHAMT : decode_pkg::IMM_I;
                end else begin
                    dec.rs2 = rs2;
                end
            end
            `INST_LUI, `INST_AUIPC: begin
                dec.op_type = (opcode == `INST_LUI) ? `INST_ALU_LUI : `INST_ALU_AUIPC;
                dec.use_pc  = (opcode == `INST_AUIPC);
                dec.use_imm = 1'b1;
                imm_fmt     = decode_pkg::IMM_U;
                use_rd      = 1'b1;
                dec.rd      = rd;
            end
            `INST_JAL: begin
                dec.op_type = `INST_BR_JAL;
                dec.op_mod  = `MOD_BITS'(1);
                dec.use_pc  = 1'b1;
                dec.use_imm = 1'b1;
                imm_fmt     = decode_pkg::IMM_J;
                use_rd      = 1'b1;
                dec.rd      = rd;
                is_wstall   = 1'b1;
            end
            `INST_JALR: begin
                dec.op_type = `INST_BR_JALR;
                dec.op_mod  = `MOD_BITS'(1);
                dec.use_imm = 1'b1;
                imm_fmt     = decode_pkg::IMM_I;
                use_rd      = 1'b1;
                dec.rd      = rd;
                dec.rs1     = rs1;
                is_wstall   = 1'b1;
            end
            `INST_B: begin
                case (func3)
                    3'h0: dec.op_type = `INST_BR_EQ;
                    3'h1: dec.op_type = `INST_BR_NE;
                    3'h4: dec.op_type = `INST_BR_LT;
                    3'h5: dec.op_type = `INST_BR_GE;
                    3'h6: dec.op_type = `INST_BR_LTU;
                    3'h7: dec.op_type = `INST_BR_GEU;
                    default: dec.op_type = `INST_BR_EQ;
                endcase
                dec.op_mod  = `MOD_BITS'(1);
                dec.use_pc  = 1'b1;
                dec.use_imm = 1'b1;
                imm_fmt     = decode_pkg::IMM_B;
                dec.rs1     = rs1;
                dec.rs2     = rs2;
                is_wstall   = 1'b1;
            end
            `INST_FENCE: begin
                dec.ex_type = decode_pkg::EX_LSU;
                dec.op_mod  = `MOD_BITS'(1);
            end
            `INST_SYS: begin
                if (func3[1:0] != 2'b00) begin
                    dec.ex_type = decode_pkg::EX_CSR;
                    dec.op_type = `OP_BITS'(func3[1:0]); // RW, RS, RC
                    dec.use_imm = func3[2];
                    imm_fmt     = decode_pkg::IMM_CSR;
                    use_rd      = 1'b1;
                    dec.rd      = rd;
                    if (!func3[2])
                        dec.rs1 = rs1;
                end else begin
                    case (u_12)
                        12'h000: dec.op_type = `INST_BR_ECALL;
                        12'h001: dec.op_type = `INST_BR_EBREAK;
                        12'h002: dec.op_type = `INST_BR_URET;
                        12'h102: dec.op_type = `INST_BR_SRET;
                        12'h302: dec.op_type = `INST_BR_MRET;
                        default: dec.op_type = `INST_BR_ECALL;
                    endcase
                    dec.op_mod  = `MOD_BITS'(1);
                    dec.use_pc  = 1'b1;
                    dec.use_imm = 1'b1;
                    imm_fmt     = decode_pkg::IMM_PC4;
                    use_rd      = 1'b1;
                    dec.rd      = rd;
                    is_wstall   = 1'b1;
                end
            end
            `INST_L: begin
                dec.ex_type = decode_pkg::EX_LSU;
                dec.op_type = `OP_BITS'({1'b0, func3});
                imm_fmt     = decode_pkg::IMM_I;
                use_rd      = 1'b1;
                dec.rd      = rd;
                dec.rs1     = rs1;
            end
            `INST_S: begin
                dec.ex_type = decode_pkg::EX_LSU;
                dec.op_type = `OP_BITS'({1'b1, func3}); // Bit 3 marks a store
                imm_fmt     = decode_pkg::IMM_S;
                dec.rs1     = rs1;
                dec.rs2     = rs2;
            end
            `INST_GPGPU: begin
                dec.ex_type = decode_pkg::EX_GPU;
                case (func3)
                    3'h0: begin
                        dec.op_type = rs2[0] ? `INST_GPU_PRED : `INST_GPU_TMC;
                        dec.rs1     = rs1;
                        is_wstall   = 1'b1;
                    end
                    3'h1: begin
                        dec.op_type = `INST_GPU_WSPAWN;
                        dec.rs1     = rs1;
                        dec.rs2     = rs2;
                    end
                    3'h2: begin
                        dec.op_type = `INST_GPU_SPLIT;
                        dec.rs1     = rs1;
                        is_wstall   = 1'b1;
                    end
                    3'h3: begin
                        dec.op_type = `INST_GPU_JOIN;
                        is_join     = 1'b1;
                    end
                    3'h4: begin
                        dec.op_type = `INST_GPU_BAR;
                        dec.rs1     = rs1;
                        dec.rs2     = rs2;
                        is_wstall   = 1'b1;
                    end
                    3'h5: begin
                        // Load routed to the LSU
                        dec.ex_type = decode_pkg::EX_LSU;
                        dec.op_type = `INST_LSU_LW;
                        dec.op_mod  = `MOD_BITS'(2);
                        dec.rs1     = rs1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase

        dec.wb = use_rd && (dec.rd != '0); // x0 is never written
    end

endmodule

/* imm_gen.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module imm_gen (
    input  logic [31:0]          instr,
    input  decode_pkg::imm_fmt_e imm_fmt,
    output logic [31:0]          imm
);

    always_comb begin
        imm = '0;
        case (imm_fmt)
            decode_pkg::IMM_I: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            decode_pkg::IMM_SHAMT: begin
                imm = {27'b0, instr[24:20]}; // Zero extended
            end
            decode_pkg::IMM_S: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            decode_pkg::IMM_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            decode_pkg::IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            decode_pkg::IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            decode_pkg::IMM_CSR: begin
                // CSR address low, uimm/rs1 field above it
                imm[`CSR_ADDR_BITS-1:0]          = instr[31:20];
                imm[`CSR_ADDR_BITS +: `NR_BITS]  = instr[19:15];
            end
            decode_pkg::IMM_PC4: begin
                imm = 32'd4; // Return address offset
            end
            default: imm = '0;
        endcase
    end

endmodule

/* decode_pkg.sv */
`include "decode_defines.svh"

package decode_pkg;

    typedef enum logic [1:0] {
        EX_ALU,
        EX_LSU,
        EX_CSR,
        EX_GPU
    } ex_type_e;

    // Nine formats need four bits
    typedef enum logic [3:0] {
        IMM_NONE,
        IMM_I,
        IMM_SHAMT,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_CSR,
        IMM_PC4
    } imm_fmt_e;

    typedef struct packed {
        logic [`UUID_BITS-1:0]   uuid;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [31:0]             pc;
        logic [31:0]             instr;
    } fetch_rsp_t;

    typedef struct packed {
        ex_type_e               ex_type;
        logic [`OP_BITS-1:0]    op_type;
        logic [`MOD_BITS-1:0]   op_mod;
        logic                   wb;
        logic [`NR_BITS-1:0]    rd;
        logic [`NR_BITS-1:0]    rs1;
        logic [`NR_BITS-1:0]    rs2;
        logic [31:0]            imm;
        logic                   use_pc;
        logic                   use_imm;
    } decoded_t;

    typedef struct packed {
        logic [`UUID_BITS-1:0]   uuid;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [31:0]             pc;
        decoded_t                dec;
    } decode_rsp_t;

    typedef struct packed {
        logic [`NW_BITS-1:0] wid;
        logic                stalled;
    } wstall_t;

    typedef struct packed {
        logic [`NW_BITS-1:0] wid;
    } join_t;

    typedef struct packed {
        logic [`PERF_CTR_BITS-1:0] loads;
        logic [`PERF_CTR_BITS-1:0] stores;
        logic [`PERF_CTR_BITS-1:0] branches;
    } perf_cnt_t;

endpackage

/* decode_defines.svh */
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define NUM_THREADS   4
`define NW_BITS       2
`define UUID_BITS     16
`define NR_BITS       5
`define PERF_CTR_BITS 32
`define OP_BITS       4
`define MOD_BITS      3
`define CSR_ADDR_BITS 12

// Major opcodes
`define INST_R     7'b0110011
`define INST_I     7'b0010011
`define INST_L     7'b0000011
`define INST_S     7'b0100011
`define INST_B     7'b1100011
`define INST_LUI   7'b0110111
`define INST_AUIPC 7'b0010111
`define INST_JAL   7'b1101111
`define INST_JALR  7'b1100111
`define INST_FENCE 7'b0001111
`define INST_SYS   7'b1110011
`define INST_GPGPU 7'h6B

`define INST_ALU_ADD   `OP_BITS'(0)
`define INST_ALU_SUB   `OP_BITS'(1)
`define INST_ALU_SLL   `OP_BITS'(2)
`define INST_ALU_SLT   `OP_BITS'(3)
`define INST_ALU_SLTU  `OP_BITS'(4)
`define INST_ALU_XOR   `OP_BITS'(5)
`define INST_ALU_SRL   `OP_BITS'(6)
`define INST_ALU_SRA   `OP_BITS'(7)
`define INST_ALU_OR    `OP_BITS'(8)
`define INST_ALU_AND   `OP_BITS'(9)
`define INST_ALU_LUI   `OP_BITS'(10)
`define INST_ALU_AUIPC `OP_BITS'(11)

// Branch class, issued with op_mod 1
`define INST_BR_EQ     `OP_BITS'(0)
`define INST_BR_NE     `OP_BITS'(1)
`define INST_BR_LT     `OP_BITS'(4)
`define INST_BR_GE     `OP_BITS'(5)
`define INST_BR_LTU    `OP_BITS'(6)
`define INST_BR_GEU    `OP_BITS'(7)
`define INST_BR_JAL    `OP_BITS'(8)
`define INST_BR_JALR   `OP_BITS'(9)
`define INST_BR_ECALL  `OP_BITS'(10)
`define INST_BR_EBREAK `OP_BITS'(11)
`define INST_BR_URET   `OP_BITS'(12)
`define INST_BR_SRET   `OP_BITS'(13)
`define INST_BR_MRET   `OP_BITS'(14)

`define INST_GPU_TMC    `OP_BITS'(0)
`define INST_GPU_WSPAWN `OP_BITS'(1)
`define INST_GPU_SPLIT  `OP_BITS'(2)
`define INST_GPU_JOIN   `OP_BITS'(3)
`define INST_GPU_BAR    `OP_BITS'(4)
`define INST_GPU_PRED   `OP_BITS'(5)

`define INST_LSU_LW `OP_BITS'(2)

`endif
